// ==== cpuCore.f ====
+incdir+logic
+incdir+tests
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/regFile.sv
logic/cpuCore.sv
tests/clockGen.sv
tests/cpuCoreTb.sv

// ==== logic/cpuCore.sv ====
`include "cpu_settings.svh"

module cpuCore
  import cpuPkg::*;
(
  input  logic iClock,
  input  logic rstN,
  output addrT fetchAddr,
  output logic fetchEnable,
  input  byteT fetchData,
  output logic storeValid,
  output addrT storeAddr,
  output byteT storeData,
  output logic halted
);

  logic   fetchValid;
  logic   haltSeen;
  execOpT execOp;
  regIdxT dstIdx;
  regIdxT srcIdx;
  byteT   immediate;
  byteT   srcData;
  byteT   accData;
  addrT   hlAddr;
  logic   regWriteEnable;
  regIdxT regWriteIdx;
  byteT   regWriteData;

  // --------------------------------------------------
  // Pipeline stages
  // --------------------------------------------------
  fetchStage i_fetchStage (
    .iClock      (iClock),
    .rstN        (rstN),
    .haltSeen    (haltSeen),
    .fetchAddr   (fetchAddr),
    .fetchEnable (fetchEnable),
    .fetchValid  (fetchValid)
  );

  decodeStage i_decodeStage (
    .iClock     (iClock),
    .rstN       (rstN),
    .fetchValid (fetchValid),
    .fetchData  (fetchData),
    .haltSeen   (haltSeen),
    .halted     (halted),
    .execOp     (execOp),
    .dstIdx     (dstIdx),
    .srcIdx     (srcIdx),
    .immediate  (immediate)
  );

  executeStage i_executeStage (
    .iClock         (iClock),
    .rstN           (rstN),
    .execOp         (execOp),
    .dstIdx         (dstIdx),
    .srcIdx         (srcIdx),
    .immediate      (immediate),
    .srcData        (srcData),
    .accData        (accData),
    .hlAddr         (hlAddr),
    .regWriteEnable (regWriteEnable),
    .regWriteIdx    (regWriteIdx),
    .regWriteData   (regWriteData),
    .storeValid     (storeValid),
    .storeAddr      (storeAddr),
    .storeData      (storeData)
  );

  // Port B always reads the accumulator
  regFile i_regFile (
    .iClock      (iClock),
    .rstN        (rstN),
    .readIdxA    (srcIdx),
    .readIdxB    (`REG_A),
    .readDataA   (srcData),
    .readDataB   (accData),
    .hlAddr      (hlAddr),
    .writeEnable (regWriteEnable),
    .writeIdx    (regWriteIdx),
    .writeData   (regWriteData)
  );

endmodule

// ==== logic/cpuPkg.sv ====
`include "cpu_settings.svh"

package cpuPkg;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------
  typedef logic [`ADDR_WIDTH-1:0] addrT;
  typedef logic [`DATA_WIDTH-1:0] byteT;
  typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;

  // --------------------------------------------------
  // Operations handed from decode to execute
  // --------------------------------------------------
  typedef enum logic [2:0]
  {
    opNop,
    opLoadImm, // dst <- immediate
    opMove,    // dst <- src
    opAnd,     // A <- A & src
    opXor,
    opOr,
    opStore    // mem[HL] <- src
  } execOpT;

  // Decode FSM
  typedef enum logic [1:0]
  {
    decOpcode,
    decImmediate, // Waiting for the operand byte of LD r,n
    decHalted
  } decodeStateT;

endpackage

// ==== logic/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define ADDR_WIDTH 16
`define DATA_WIDTH 8
`define REG_IDX_WIDTH 3

// --------------------------------------------------
// Register indices as encoded in the opcode fields
// --------------------------------------------------
`define REG_H 3'd4
`define REG_L 3'd5
`define REG_MEM 3'd6 // (HL) slot, no storage behind it
`define REG_A 3'd7

`define RESET_PC 16'h0000 // First fetch address

`endif

// ==== logic/decodeStage.sv ====
`include "cpu_settings.svh"

module decodeStage
  import cpuPkg::*;
(
  input  logic   iClock,
  input  logic   rstN,
  input  logic   fetchValid,
  input  byteT   fetchData,
  output logic   haltSeen,
  output logic   halted,
  output execOpT execOp,
  output regIdxT dstIdx,
  output regIdxT srcIdx,
  output byteT   immediate
);

  localparam byteT haltOpcode = 8'h76;

  decodeStateT state;
  decodeStateT nextState;
  execOpT      nextOp;
  regIdxT      dstField;
  regIdxT      srcField;

  assign dstField = fetchData[5:3];
  assign srcField = fetchData[2:0];
  assign haltSeen = (state == decHalted);

  // --------------------------------------------------
  // Opcode classification
  // --------------------------------------------------
  always_comb
  begin
    nextOp    = opNop; // Bubble unless a byte completes an instruction
    nextState = state;
    if (fetchValid)
    begin
      case (state)
        decOpcode:
        begin
          if (fetchData == haltOpcode)
            nextState = decHalted;
          else
          begin
            case (fetchData[7:6])
              2'b00:
                if (srcField == 3'b110 && dstField != `REG_MEM)
                  nextState = decImmediate; // LD r,n
              2'b01:
                if (dstField == `REG_MEM && srcField != `REG_MEM)
                  nextOp = opStore; // LD (HL),r
                else if (dstField != `REG_MEM && srcField != `REG_MEM)
                  nextOp = opMove;
              2'b10:
                if (srcField != `REG_MEM)
                begin
                  case (dstField)
                    3'b100: nextOp = opAnd;
                    3'b101: nextOp = opXor;
                    3'b110: nextOp = opOr;
                    default: nextOp = opNop;
                  endcase
                end
              default: nextOp = opNop;
            endcase
          end
        end
        decImmediate:
        begin
          nextOp    = opLoadImm;
          nextState = decOpcode;
        end
        default: nextOp = opNop; // Halted, bytes are dropped
      endcase
    end
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      state  <= decOpcode;
      execOp <= opNop;
      halted <= 1'b0;
    end
    else
    begin
      state  <= nextState;
      execOp <= nextOp;
      halted <= halted | haltSeen; // Sticky until reset
    end
  end

  // Operand fields
  always_ff @(posedge iClock)
  begin
    if (fetchValid && state == decOpcode)
    begin
      dstIdx <= dstField;
      srcIdx <= srcField;
    end
    if (fetchValid && state == decImmediate)
      immediate <= fetchData;
  end

endmodule

// ==== logic/executeStage.sv ====
`include "cpu_settings.svh"

module executeStage
  import cpuPkg::*;
(
  input  logic   iClock,
  input  logic   rstN,
  input  execOpT execOp,
  input  regIdxT dstIdx,
  input  regIdxT srcIdx,
  input  byteT   immediate,
  input  byteT   srcData,
  input  byteT   accData,
  input  addrT   hlAddr,
  output logic   regWriteEnable,
  output regIdxT regWriteIdx,
  output byteT   regWriteData,
  output logic   storeValid,
  output addrT   storeAddr,
  output byteT   storeData
);

  // --------------------------------------------------
  // Result select
  // --------------------------------------------------
  // Register writes land on the edge that ends this cycle
  always_comb
  begin
    regWriteEnable = 1'b1;
    regWriteIdx    = dstIdx;
    regWriteData   = srcData;
    case (execOp)
      opLoadImm:
        regWriteData = immediate;
      opMove:
        regWriteData = srcData;
      opAnd:
      begin
        regWriteIdx  = `REG_A;
        regWriteData = accData & srcData;
      end
      opXor:
      begin
        regWriteIdx  = `REG_A;
        regWriteData = accData ^ srcData;
      end
      opOr:
      begin
        regWriteIdx  = `REG_A;
        regWriteData = accData | srcData;
      end
      default:
        regWriteEnable = 1'b0; // opNop and opStore
    endcase
  end

  // --------------------------------------------------
  // Store port
  // --------------------------------------------------
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      storeValid <= 1'b0;
    else
      storeValid <= (execOp == opStore);
  end

  always_ff @(posedge iClock)
  begin
    if (execOp == opStore)
    begin
      storeAddr <= hlAddr; // H:L as it stands after the previous op
      storeData <= srcData;
    end
  end

endmodule

// ==== logic/fetchStage.sv ====
`include "cpu_settings.svh"

module fetchStage
  import cpuPkg::*;
(
  input  logic iClock,
  input  logic rstN,
  input  logic haltSeen,
  output addrT fetchAddr,
  output logic fetchEnable,
  output logic fetchValid
);

  // --------------------------------------------------
  // Program counter
  // --------------------------------------------------
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      fetchAddr   <= `RESET_PC;
      fetchEnable <= 1'b0;
    end
    else
    begin
      fetchEnable <= !haltSeen; // Stop reading once HALT is decoded
      if (fetchEnable && !haltSeen)
        fetchAddr <= fetchAddr + 1'b1;
    end
  end

  // Memory answers one cycle after the request
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      fetchValid <= 1'b0;
    else
      fetchValid <= fetchEnable;
  end

endmodule

// ==== logic/regFile.sv ====
`include "cpu_settings.svh"

module regFile
  import cpuPkg::*;
(
  input  logic   iClock,
  input  logic   rstN,
  input  regIdxT readIdxA,
  input  regIdxT readIdxB,
  output byteT   readDataA,
  output byteT   readDataB,
  output addrT   hlAddr,
  input  logic   writeEnable,
  input  regIdxT writeIdx,
  input  byteT   writeData
);

  // B C D E H L - A, slot 6 never written and reads as zero
  byteT regs [0:7];

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
    end
    else if (writeEnable && writeIdx != `REG_MEM)
      regs[writeIdx] <= writeData;
  end

  // --------------------------------------------------
  // Combinational reads
  // --------------------------------------------------
  assign readDataA = regs[readIdxA];
  assign readDataB = regs[readIdxB];
  assign hlAddr    = {regs[`REG_H], regs[`REG_L]}; // H is the high byte

endmodule

// ==== tests/clockGen.sv ====
module clockGen
(
  input  logic resetRequest,
  output logic iClock,
  output logic rstN
);

  int lowLeft; // Reset cycles still to go

  initial
  begin
    iClock  = 1'b0;
    rstN    = 1'b0;
    lowLeft = 5;
    forever #50 iClock = ~iClock;
  end

  // A request restarts the 5 cycle reset
  always @(posedge iClock)
  begin
    if (resetRequest)
    begin
      rstN    <= 1'b0;
      lowLeft <= 5;
    end
    else if (lowLeft > 0)
    begin
      lowLeft <= lowLeft - 1;
      rstN    <= (lowLeft == 1);
    end
  end

endmodule

// ==== tests/cpuModel.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

typedef logic [23:0] storeT; // {address, data}
typedef storeT storeListT [$];

// --------------------------------------------------
// Instruction set model, runs from address 0 to HALT
// --------------------------------------------------
function automatic storeListT runModel(input byteT image [0:255]);
  byteT      regs [0:7];
  storeListT stores;
  int        pc;
  byteT      op;
  regIdxT    dst;
  regIdxT    src;
  logic      running;
  for (int i = 0; i < 8; i++)
    regs[i] = '0;
  pc      = 0;
  running = 1'b1;
  while (running && pc < 256)
  begin
    op  = image[pc];
    dst = op[5:3];
    src = op[2:0];
    pc++;
    if (op == 8'h76)
      running = 1'b0;
    else if (op[7:6] == 2'b00 && src == `REG_MEM && dst != `REG_MEM)
    begin
      regs[dst] = image[pc]; // LD r,n takes the next byte
      pc++;
    end
    else if (op[7:6] == 2'b01 && dst == `REG_MEM && src != `REG_MEM)
      stores.push_back({regs[`REG_H], regs[`REG_L], regs[src]});
    else if (op[7:6] == 2'b01 && dst != `REG_MEM && src != `REG_MEM)
      regs[dst] = regs[src];
    else if (op[7:6] == 2'b10 && src != `REG_MEM)
    begin
      case (dst)
        3'd4: regs[`REG_A] = regs[`REG_A] & regs[src];
        3'd5: regs[`REG_A] = regs[`REG_A] ^ regs[src];
        3'd6: regs[`REG_A] = regs[`REG_A] | regs[src];
        default: ; // Everything else is a NOP
      endcase
    end
  end
  return stores;
endfunction

`endif

// ==== tests/cpuCoreTb.sv ====
`include "cpu_settings.svh"

module cpuCoreTb
  import cpuPkg::*;
();

  `include "cpuModel.svh"

  localparam logic [2:0] aluAnd = 3'b100;
  localparam logic [2:0] aluXor = 3'b101;
  localparam logic [2:0] aluOr  = 3'b110;

  logic      iClock;
  logic      rstN;
  logic      resetRequest;
  addrT      fetchAddr;
  logic      fetchEnable;
  byteT      fetchData;
  logic      storeValid;
  addrT      storeAddr;
  byteT      storeData;
  logic      halted;
  byteT      mem [0:255];
  byteT      progBytes [$];
  storeListT expected;
  int        storeIdx;
  logic      testActive;
  logic      haltDone;
  addrT      haltAddr;
  int        cycleCount;
  int        cycleLimit;

  clockGen clockSource (
    .resetRequest (resetRequest),
    .iClock       (iClock),
    .rstN         (rstN)
  );

  cpuCore i_cpuCore (
    .iClock      (iClock),
    .rstN        (rstN),
    .fetchAddr   (fetchAddr),
    .fetchEnable (fetchEnable),
    .fetchData   (fetchData),
    .storeValid  (storeValid),
    .storeAddr   (storeAddr),
    .storeData   (storeData),
    .halted      (halted)
  );

  // Instruction memory, one cycle read
  always @(posedge iClock)
  begin
    if (fetchEnable)
      fetchData <= mem[fetchAddr[7:0]];
  end

  task automatic failRun(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1);
  endtask

  // --------------------------------------------------
  // Comparator
  // --------------------------------------------------
  always @(negedge iClock)
  begin
    if (testActive && rstN)
    begin
      if (storeValid)
      begin
        assert (!halted && storeIdx < expected.size())
        else
          failRun("A store appeared that the program does not produce");
        assert (storeAddr == expected[storeIdx][23:8])
        else
          failRun($sformatf("** Error at %0t: storeAddr = 0x%h, expected 0x%h",
                            $time, storeAddr, expected[storeIdx][23:8]));
        assert (storeData == expected[storeIdx][7:0])
        else
          failRun($sformatf("** Error at %0t: storeData = 0x%h, expected 0x%h",
                            $time, storeData, expected[storeIdx][7:0]));
        storeIdx++;
      end
      // Fetch runs every cycle from the first one after reset until halt
      if (!halted)
      begin
        assert (fetchEnable || fetchAddr == `RESET_PC)
        else
          failRun($sformatf("** Error at %0t: fetchEnable = %b, expected 1",
                            $time, fetchEnable));
      end
      if (halted && !haltDone)
      begin
        assert (storeIdx == expected.size())
        else
          failRun($sformatf("Halted after %0d of %0d expected stores",
                            storeIdx, expected.size()));
        haltDone = 1'b1;
        haltAddr = fetchAddr;
      end
      else if (haltDone)
      begin
        assert (halted)
        else
          failRun($sformatf("** Error at %0t: halted = %b, expected 1", $time, halted));
        assert (fetchAddr == haltAddr)
        else
          failRun($sformatf("** Error at %0t: fetchAddr = 0x%h, expected 0x%h",
                            $time, fetchAddr, haltAddr));
      end
    end
  end

  always @(posedge iClock)
  begin
    if (testActive && !haltDone)
    begin
      cycleCount++;
      if (cycleCount > cycleLimit)
        failRun($sformatf("Timeout: the core did not halt within %0d cycles", cycleLimit));
    end
  end

  // --------------------------------------------------
  // Program building
  // --------------------------------------------------
  function automatic void loadImm(input regIdxT r, input byteT n);
    progBytes.push_back({2'b00, r, 3'b110});
    progBytes.push_back(n);
  endfunction

  function automatic void move(input regIdxT dst, input regIdxT src);
    progBytes.push_back({2'b01, dst, src});
  endfunction

  function automatic void store(input regIdxT src);
    progBytes.push_back({2'b01, `REG_MEM, src});
  endfunction

  function automatic void alu(input logic [2:0] kind, input regIdxT src);
    progBytes.push_back({2'b10, kind, src});
  endfunction

  function automatic regIdxT randomReg();
    regIdxT r;
    r = regIdxT'($urandom % 7);
    return (r == `REG_MEM) ? `REG_A : r; // Never the (HL) slot
  endfunction

  function automatic void addRandomInstruction(input int room);
    int kind;
    kind = (room > 1) ? $urandom % 6 : 1 + $urandom % 5;
    case (kind)
      0: loadImm(randomReg(), byteT'($urandom));
      1: move(randomReg(), randomReg());
      2: store(randomReg());
      3: alu(aluAnd, randomReg());
      4: alu(aluXor, randomReg());
      default: alu(aluOr, randomReg());
    endcase
  endfunction

  task automatic resetDut();
    @(posedge iClock);
    resetRequest <= 1'b1;
    @(posedge iClock);
    resetRequest <= 1'b0;
    do
      @(negedge iClock);
    while (!rstN);
  endtask

  // Appends HALT, loads memory, resets and runs until halted
  task automatic runProgram(input string name);
    progBytes.push_back(8'h76);
    for (int a = 0; a < 256; a++)
      mem[a] = (a < progBytes.size()) ? progBytes[a] : byteT'(a * 37 + 11);
    expected   = runModel(mem);
    cycleLimit = 4 * progBytes.size() + 50;
    cycleCount = 0;
    storeIdx   = 0;
    haltDone   = 1'b0;
    resetDut();
    testActive = 1'b1;
    while (!haltDone)
      @(negedge iClock);
    repeat (10) @(negedge iClock); // fetchAddr must hold while halted
    testActive = 1'b0;
    $display("%s: %0d stores checked", name, expected.size());
    progBytes.delete();
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  initial
  begin
    void'($urandom(59085));
    resetRequest = 1'b0;
    fetchData    = '0;
    testActive   = 1'b0;
    haltDone     = 1'b0;
    storeIdx     = 0;
    cycleCount   = 0;
    cycleLimit   = 0;

    for (int r = 0; r < 8; r++)
      if (r != `REG_MEM)
        loadImm(regIdxT'(r), byteT'(8'h13 * (r + 1)));
    for (int r = 0; r < 8; r++)
      if (r != `REG_MEM)
        store(regIdxT'(r));
    runProgram("Immediate loads");

    loadImm(3'd0, 8'hA7);
    move(3'd1, 3'd0);
    move(3'd2, 3'd1);
    move(3'd3, 3'd2);
    move(`REG_A, 3'd3);
    move(`REG_H, `REG_A);
    move(`REG_L, 3'd1);
    for (int r = 0; r < 8; r++)
      if (r != `REG_MEM)
        store(regIdxT'(r));
    runProgram("Register moves");

    for (int r = 0; r < 8; r++)
      if (r != `REG_MEM)
        loadImm(regIdxT'(r), byteT'(8'h5A + 8'h29 * r));
    for (int r = 0; r < 8; r++)
      if (r != `REG_MEM)
      begin
        alu(aluOr, regIdxT'(r));
        store(`REG_A);
        alu(aluXor, regIdxT'(r));
        store(`REG_A);
        alu(aluAnd, regIdxT'(r));
        store(`REG_A);
      end
    runProgram("Logic operations");

    // Every instruction uses the result of the one before it
    loadImm(`REG_L, 8'h3C);
    move(`REG_H, `REG_L);
    store(`REG_H);
    loadImm(`REG_A, 8'h0F);
    alu(aluXor, `REG_L);
    move(3'd0, `REG_A);
    alu(aluOr, 3'd0);
    store(3'd0);
    move(`REG_L, `REG_A);
    store(`REG_L);
    alu(aluXor, `REG_A);
    store(`REG_A);
    runProgram("Dependent instructions");

    loadImm(`REG_A, 8'hC3);
    store(`REG_A);
    progBytes.push_back(8'h76);
    store(`REG_A);
    loadImm(`REG_A, 8'h01);
    store(`REG_A);
    runProgram("Halt");

    for (int t = 0; t < 20; t++)
    begin
      while (progBytes.size() < 39)
        addRandomInstruction(39 - progBytes.size());
      runProgram($sformatf("Random program %0d", t));
    end

    $display("test passed");
    $finish;
  end

endmodule
